/* cmd_bridge_pkg.sv */
//****************************************
// shared types of the command bridge
// - source number and register address
// - write and read views of a command body
// - command word and read response word
//****************************************
package cmd_bridge_pkg;

  // producers feeding the bridge
  localparam int n_src = 2;
  typedef logic [$clog2(n_src)-1:0] src_idx_t;

  // register bank geometry, one byte per register
  localparam int addr_w    = 4;
  localparam int reg_count = 2 ** addr_w;
  typedef logic [addr_w-1:0] reg_addr_t;

  // operation bit selects how the body is decoded
  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } cmd_op_e;

  //****************************************
  // command body views, 12 bits each
  //****************************************
  // write view: target register and new value
  typedef struct packed {
    reg_addr_t  addr;
    logic [7:0] data;
  } cmd_wr_t;

  // read view: source register and a tag echoed in the response
  typedef struct packed {
    reg_addr_t  addr;
    logic [7:0] tag;
  } cmd_rd_t;

  typedef union packed {
    cmd_wr_t wr;
    cmd_rd_t rd;
  } cmd_body_u;

  // command word, 13 bits, carried through the FIFOs
  typedef struct packed {
    cmd_op_e   op;
    cmd_body_u body;
  } cmd_t;

  // read response, 17 bits
  typedef struct packed {
    src_idx_t   src;
    logic [7:0] tag;
    logic [7:0] data;
  } rsp_t;

endpackage

/* async_gp_fifo.sv */
//****************************************
// asynchronous FIFO for command words
// - binary pointers with one wrap bit
// - gray pointers cross through two flops
// - full in write domain, empty in read domain
//****************************************
`timescale 1ns/10ps

module async_gp_fifo import cmd_bridge_pkg::*; #(
  parameter int SLOTS = 4
) (
  // source clock domain
  input  logic wr_clk,
  input  logic wr_arst,
  input  logic wr_en,
  input  cmd_t wr_data,
  output logic wr_full,
  // consumer clock domain
  input  logic rd_clk,
  input  logic rd_arst,
  input  logic rd_en,
  output cmd_t rd_data,
  output logic rd_empty
);

  localparam int aw = $clog2(SLOTS);

  // index bits plus one wrap bit
  typedef logic [aw:0] ptr_t;

  // command storage, written in wr_clk and read in rd_clk
  cmd_t mem [SLOTS];

  // w_ prefix lives in wr_clk, r_ prefix lives in rd_clk
  ptr_t w_wr_bin_ptr, w_wr_bin_nxt, w_wr_gry_ptr;
  ptr_t w_rd_gry_meta, w_rd_gry_ptr, w_rd_bin_ptr;
  ptr_t r_rd_bin_ptr, r_rd_bin_nxt, r_rd_gry_ptr;
  ptr_t r_wr_gry_meta, r_wr_gry_ptr;
  logic [aw-1:0] wr_idx;
  logic [aw-1:0] rd_idx;
  logic wr_push;
  logic rd_pop;

  //****************************************
  // pointer encoding
  //****************************************
  function automatic ptr_t bin_to_gray(ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction

  function automatic ptr_t gray_to_bin(ptr_t gray);
    ptr_t bin;
    bin = gray;
    // each bit folds in the already decoded bit above it
    for (int i = aw; i > 0; i--) begin
      bin[i-1] = bin[i] ^ bin[i-1];
    end
    return bin;
  endfunction

  //****************************************
  // write side
  //****************************************
  always_comb begin
    wr_idx       = w_wr_bin_ptr[aw-1:0];
    w_rd_bin_ptr = gray_to_bin(w_rd_gry_ptr);
    // one lap ahead of the reader: wrap bits differ, index equal
    wr_full      = (w_wr_bin_ptr[aw] != w_rd_bin_ptr[aw]) &&
                   (wr_idx == w_rd_bin_ptr[aw-1:0]);
    wr_push      = wr_en && !wr_full;
    w_wr_bin_nxt = w_wr_bin_ptr + ptr_t'(wr_push);
  end

  always_ff @(posedge wr_clk or posedge wr_arst) begin
    if (wr_arst) begin
      w_wr_bin_ptr  <= '0;
      w_wr_gry_ptr  <= '0;
      w_rd_gry_meta <= '0;
      w_rd_gry_ptr  <= '0;
    end else begin
      w_wr_bin_ptr  <= w_wr_bin_nxt;
      // gray copy registered so the crossing sees a clean flop output
      w_wr_gry_ptr  <= bin_to_gray(w_wr_bin_nxt);
      // read pointer into the write domain
      w_rd_gry_meta <= r_rd_gry_ptr;
      w_rd_gry_ptr  <= w_rd_gry_meta;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_push) begin
      mem[wr_idx] <= wr_data;
    end
  end

  //****************************************
  // read side
  //****************************************
  always_comb begin
    rd_idx       = r_rd_bin_ptr[aw-1:0];
    // empty when the synced write pointer matches our own
    rd_empty     = (r_rd_gry_ptr == r_wr_gry_ptr);
    rd_pop       = rd_en && !rd_empty;
    r_rd_bin_nxt = r_rd_bin_ptr + ptr_t'(rd_pop);
    // head word shown without a read latency
    rd_data      = mem[rd_idx];
  end

  always_ff @(posedge rd_clk or posedge rd_arst) begin
    if (rd_arst) begin
      r_rd_bin_ptr  <= '0;
      r_rd_gry_ptr  <= '0;
      r_wr_gry_meta <= '0;
      r_wr_gry_ptr  <= '0;
    end else begin
      r_rd_bin_ptr  <= r_rd_bin_nxt;
      r_rd_gry_ptr  <= bin_to_gray(r_rd_bin_nxt);
      // write pointer into the read domain
      r_wr_gry_meta <= w_wr_gry_ptr;
      r_wr_gry_ptr  <= r_wr_gry_meta;
    end
  end

endmodule

/* rr_arbiter.sv */
//****************************************
// round-robin arbiter for two FIFOs
// - combinational grant and pop
// - last winner register
//****************************************
`timescale 1ns/10ps

module rr_arbiter import cmd_bridge_pkg::*; (
  input  logic                 rd_clk,
  input  logic                 rd_arst,
  input  logic [n_src-1:0]     empty,
  input  cmd_t [n_src-1:0]     cmd_in,
  output logic [n_src-1:0]     pop,
  output logic                 grant,
  output src_idx_t             grant_src,
  output cmd_t                 grant_cmd
);

  // source that won the most recent grant
  src_idx_t last_win;
  // source that did not win last, first in line
  src_idx_t pref;

  //****************************************
  // grant decision
  //****************************************
  always_comb begin
    pref  = ~last_win;
    grant = !(&empty);
    // other source if it has work, else stay with the last winner
    if (!empty[pref]) begin
      grant_src = pref;
    end else begin
      grant_src = last_win;
    end
    // exactly one pop bit when something is granted
    pop            = '0;
    pop[grant_src] = grant;
    grant_cmd      = cmd_in[grant_src];
  end

  // start with source 0 preferred
  always_ff @(posedge rd_clk or posedge rd_arst) begin
    if (rd_arst) begin
      last_win <= src_idx_t'(n_src - 1);
    end else if (grant) begin
      last_win <= grant_src;
    end
  end

endmodule

/* reg_bank.sv */
//****************************************
// 16-byte register bank
// - writes land at the grant edge
// - reads answer one cycle later
//****************************************
`timescale 1ns/10ps

module reg_bank import cmd_bridge_pkg::*; (
  input  logic     rd_clk,
  input  logic     rd_arst,
  input  logic     grant,
  input  src_idx_t grant_src,
  input  cmd_t     grant_cmd,
  output rsp_t     rsp,
  output logic     rsp_valid
);

  // register contents, cleared by reset
  logic [7:0] regs [reg_count];

  // both views of the granted body
  cmd_wr_t wr_view;
  cmd_rd_t rd_view;
  logic    do_write;
  logic    do_read;

  //****************************************
  // command decode
  //****************************************
  always_comb begin
    wr_view  = grant_cmd.body.wr;
    rd_view  = grant_cmd.body.rd;
    do_write = grant && (grant_cmd.op == op_write);
    do_read  = grant && (grant_cmd.op == op_read);
  end

  // register update
  always_ff @(posedge rd_clk or posedge rd_arst) begin
    if (rd_arst) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (do_write) begin
      regs[wr_view.addr] <= wr_view.data;
    end
  end

  //****************************************
  // read response
  //****************************************
  // payload only loads on a read, old contents since one grant per cycle
  always_ff @(posedge rd_clk) begin
    if (do_read) begin
      rsp.src  <= grant_src;
      rsp.tag  <= rd_view.tag;
      rsp.data <= regs[rd_view.addr];
    end
  end

  // single-cycle strobe
  always_ff @(posedge rd_clk or posedge rd_arst) begin
    if (rd_arst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= do_read;
    end
  end

endmodule

/* cmd_bridge_top.sv */
//****************************************
// two-source command bridge top
// - one async FIFO per producer clock
// - round-robin arbiter in rd_clk
// - shared register bank with read responses
//****************************************
`timescale 1ns/10ps

module cmd_bridge_top import cmd_bridge_pkg::*; #(
  // FIFO depth, a power of two and at least 2
  parameter int SLOTS = 4
) (
  // source 0, own clock
  input  logic src0_clk,
  input  logic src0_arst,
  input  logic src0_valid,
  input  cmd_t src0_cmd,
  output logic src0_full,
  // source 1, own clock
  input  logic src1_clk,
  input  logic src1_arst,
  input  logic src1_valid,
  input  cmd_t src1_cmd,
  output logic src1_full,
  // bank clock domain
  input  logic rd_clk,
  input  logic rd_arst,
  output rsp_t rsp,
  output logic rsp_valid
);

  //****************************************
  // rd_clk side wiring
  //****************************************
  // FIFO heads and flags, indexed by source
  logic [n_src-1:0] fifo_empty;
  cmd_t [n_src-1:0] fifo_data;
  logic [n_src-1:0] fifo_pop;

  // granted command toward the bank
  logic     grant;
  src_idx_t grant_src;
  cmd_t     grant_cmd;

  // source 0 crossing
  async_gp_fifo #(
    .SLOTS    (SLOTS)
  ) u_fifo0 (
    .wr_clk   (src0_clk),
    .wr_arst  (src0_arst),
    .wr_en    (src0_valid),
    .wr_data  (src0_cmd),
    .wr_full  (src0_full),
    .rd_clk   (rd_clk),
    .rd_arst  (rd_arst),
    .rd_en    (fifo_pop[0]),
    .rd_data  (fifo_data[0]),
    .rd_empty (fifo_empty[0])
  );

  // source 1 crossing
  async_gp_fifo #(
    .SLOTS    (SLOTS)
  ) u_fifo1 (
    .wr_clk   (src1_clk),
    .wr_arst  (src1_arst),
    .wr_en    (src1_valid),
    .wr_data  (src1_cmd),
    .wr_full  (src1_full),
    .rd_clk   (rd_clk),
    .rd_arst  (rd_arst),
    .rd_en    (fifo_pop[1]),
    .rd_data  (fifo_data[1]),
    .rd_empty (fifo_empty[1])
  );

  // one pop per cycle, alternating under load
  rr_arbiter u_arb (
    .rd_clk    (rd_clk),
    .rd_arst   (rd_arst),
    .empty     (fifo_empty),
    .cmd_in    (fifo_data),
    .pop       (fifo_pop),
    .grant     (grant),
    .grant_src (grant_src),
    .grant_cmd (grant_cmd)
  );

  reg_bank u_bank (
    .rd_clk    (rd_clk),
    .rd_arst   (rd_arst),
    .grant     (grant),
    .grant_src (grant_src),
    .grant_cmd (grant_cmd),
    .rsp       (rsp),
    .rsp_valid (rsp_valid)
  );

endmodule

/* tb_cmd_bridge.sv */
//****************************************
// testbench for the command bridge
// - three clocks, reset, per-source stimulus
// - register model and response queues
// - compare tasks, watchdog, summary
//****************************************
`timescale 1ns/10ps

module tb_cmd_bridge import cmd_bridge_pkg::*;;

  localparam int slots  = 4;
  // commands issued by tests 1 to 5
  localparam int n_cmds = 32 + 16 + 80 + (slots + 1) + 120;
  localparam longint timeout_ns = (200 * longint'(n_cmds) + 1000) * 10;

  logic src0_clk = 1'b0;
  logic src1_clk = 1'b0;
  logic rd_clk   = 1'b0;
  logic rd_run   = 1'b1;
  logic src0_arst, src1_arst, rd_arst;
  logic src0_valid, src1_valid;
  cmd_t src0_cmd, src1_cmd;
  logic src0_full, src1_full;
  rsp_t rsp;
  logic rsp_valid;

  // register model and expected responses per source
  logic [7:0] model [reg_count];
  rsp_t exp_q0 [$];
  rsp_t exp_q1 [$];
  int errors = 0;
  int err_mark = 0;
  int tests_run = 0;
  int tests_bad = 0;

  cmd_bridge_top #(.SLOTS(slots)) uut (.*);

  //****************************************
  // clocks
  //****************************************
  // rd_clk can be held by clearing rd_run
  always begin
    #5;
    if (rd_run) begin
      rd_clk = ~rd_clk;
    end
  end
  always #3.5 src0_clk = ~src0_clk;
  always #6.5 src1_clk = ~src1_clk;

  //****************************************
  // reference model and checks
  //****************************************
  // expected read response; a write only updates the model
  function automatic rsp_t ref_rsp(input int s, input cmd_t c);
    rsp_t r;
    r.src  = src_idx_t'(s);
    r.tag  = c.body.rd.tag;
    r.data = model[c.body.rd.addr];
    if (c.op == op_write) begin
      model[c.body.wr.addr] = c.body.wr.data;
    end
    return r;
  endfunction

  function automatic cmd_t mk_cmd(input cmd_op_e op, input reg_addr_t addr,
                                  input logic [7:0] val);
    cmd_t c;
    c.op = op;
    if (op == op_write) begin
      c.body.wr.addr = addr;
      c.body.wr.data = val;
    end else begin
      c.body.rd.addr = addr;
      c.body.rd.tag  = val;
    end
    return c;
  endfunction

  task automatic check_rsp(input rsp_t exp, input rsp_t act);
    if (act !== exp) begin
      errors++;
      $display("error %0t ns rsp exp src=%0d tag=%h data=%h act src=%0d tag=%h data=%h",
               $time, exp.src, exp.tag, exp.data, act.src, act.tag, act.data);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("error %0t ns %s exp=%b act=%b", $time, name, exp, act);
    end
  endtask

  // match each response against the head of its source queue
  task automatic take_rsp(input rsp_t act);
    rsp_t exp;
    if (act.src == 1'b0 && exp_q0.size() != 0) begin
      exp = exp_q0.pop_front();
      check_rsp(exp, act);
    end else if (act.src == 1'b1 && exp_q1.size() != 0) begin
      exp = exp_q1.pop_front();
      check_rsp(exp, act);
    end else begin
      errors++;
      $display("response for source %0d at %0t ns with nothing outstanding", act.src, $time);
    end
  endtask

  // outputs settle after the rising edge, sample on the falling one
  always @(negedge rd_clk) begin
    if (!rd_arst && rsp_valid) begin
      take_rsp(rsp);
    end
  end

  //****************************************
  // stimulus helpers
  //****************************************
  task automatic wait_src_edge(input int s);
    if (s == 0) begin
      @(posedge src0_clk);
    end else begin
      @(posedge src1_clk);
    end
    #1;
  endtask

  task automatic drive(input int s, input logic v, input cmd_t c);
    if (s == 0) begin
      src0_cmd   = c;
      src0_valid = v;
    end else begin
      src1_cmd   = c;
      src1_valid = v;
    end
  endtask

  // queue the expectation, then strobe once full is low
  task automatic issue(input int s, input cmd_t c);
    rsp_t e;
    e = ref_rsp(s, c);
    if (c.op == op_read && s == 0) begin
      exp_q0.push_back(e);
    end else if (c.op == op_read) begin
      exp_q1.push_back(e);
    end
    wait_src_edge(s);
    while ((s == 0) ? src0_full : src1_full) begin
      wait_src_edge(s);
    end
    drive(s, 1'b1, c);
    wait_src_edge(s);
    drive(s, 1'b0, c);
  endtask

  // random mix on the source's own address half
  task automatic random_stream(input int s, input int n, input bit reads_only);
    cmd_op_e   op;
    reg_addr_t a;
    for (int k = 0; k < n; k++) begin
      op = (reads_only || $urandom_range(1) == 1) ? op_read : op_write;
      a  = reg_addr_t'(8 * s) | reg_addr_t'($urandom_range(7));
      issue(s, mk_cmd(op, a, 8'($urandom)));
    end
  endtask

  task automatic wait_drain();
    while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      @(negedge rd_clk);
    end
    repeat (4) @(posedge rd_clk);
  endtask

  task automatic end_test(input int num, input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: fail, %0d errors", num, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  //****************************************
  // watchdog
  //****************************************
  initial begin
    #(timeout_ns);
    $display("timeout after %0d ns, responses still outstanding", timeout_ns);
    $display("TEST FAILED");
    $finish;
  end

  //****************************************
  // test sequence
  //****************************************
  initial begin
    void'($urandom(95619));
    for (int k = 0; k < reg_count; k++) begin
      model[k] = '0;
    end
    {src0_arst, src1_arst, rd_arst} = 3'b111;
    drive(0, 1'b0, '0);
    drive(1, 1'b0, '0);
    repeat (10) @(posedge rd_clk);
    #1;
    {src0_arst, src1_arst, rd_arst} = 3'b000;
    check_flag("rsp_valid", 1'b0, rsp_valid);
    check_flag("src0_full", 1'b0, src0_full);
    check_flag("src1_full", 1'b0, src1_full);

    // every register reads zero from either source
    fork
      for (int k = 0; k < reg_count; k++) issue(0, mk_cmd(op_read, reg_addr_t'(k), 8'($urandom)));
      for (int k = 0; k < reg_count; k++) issue(1, mk_cmd(op_read, reg_addr_t'(k), 8'($urandom)));
    join
    wait_drain();
    end_test(1, "reset reads");

    for (int k = 0; k < 8; k++) issue(0, mk_cmd(op_write, reg_addr_t'(k), 8'($urandom)));
    for (int k = 0; k < 8; k++) issue(0, mk_cmd(op_read, reg_addr_t'(k), 8'($urandom)));
    wait_drain();
    end_test(2, "write then read");

    fork
      random_stream(0, 40, 1'b0);
      random_stream(1, 40, 1'b0);
    join
    wait_drain();
    end_test(3, "concurrent random");

    // hold rd_clk so source 0 fills its FIFO
    @(posedge rd_clk);
    #1;
    rd_run = 1'b0;
    for (int k = 0; k < slots; k++) issue(0, mk_cmd(op_read, reg_addr_t'(k), 8'($urandom)));
    check_flag("src0_full", 1'b1, src0_full);
    fork
      issue(0, mk_cmd(op_read, reg_addr_t'(7), 8'($urandom)));
      begin
        repeat (8) begin
          wait_src_edge(0);
          check_flag("src0_full", 1'b1, src0_full);
        end
        rd_run = 1'b1;
      end
    join
    wait_drain();
    end_test(4, "full back-pressure");

    fork
      random_stream(0, 60, 1'b1);
      random_stream(1, 60, 1'b1);
      begin
        // both sources in flight, then watch for the first one to run dry
        while (exp_q0.size() == 0 || exp_q1.size() == 0) begin
          @(posedge rd_clk);
        end
        while (exp_q0.size() != 0 && exp_q1.size() != 0) begin
          @(posedge rd_clk);
        end
        if (exp_q0.size() > slots || exp_q1.size() > slots) begin
          errors++;
          $display("one source still waits on %0d responses after the other emptied",
                   exp_q0.size() + exp_q1.size());
        end
      end
    join
    wait_drain();
    end_test(5, "read burst");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
cmd_bridge_pkg.sv
async_gp_fifo.sv
rr_arbiter.sv
reg_bank.sv
cmd_bridge_top.sv
tb_cmd_bridge.sv

/* Makefile */
# Verilator build and run of the command bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_cmd_bridge
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for a failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
